/* tests/chip_shell_testdata.txt */
# stimulus: name tap dft gpio pins mio_out mio_oe dio_out dio_oe jtag_rsp{tdo,tdo_oe}
# expected: mio_in dio_in jtag_req{tck,tms,trst_n,tdi} gpio_d2p gpio_en_d2p misc
# pins = {uart_rx, sck, csb, sdi, usb_sense, usb_dp, usb_dn}
# misc = {uart_tx, uart_tx_en, spi_sdo, spi_sdo_en, usb_dp, usb_dp_en, usb_dn, usb_dn_en}
# tap and dft are the strap levels held on the gpio pins during power-up
# spi pads with the core
all_zero 0 0 00000000 00 0000000000 0000000000 00 00 0
0000000000 00 0 00000000 00000000 00
gpio_pattern 0 0 a5a5a5a5 04 1fffffffff 0f0f0f0f0f 00 00 0
18a5a5a5a5 00 0 fbffffff 0b0f0f0f c0
uart_rx_high 0 0 00000000 40 0004000000 0004000000 00 00 0
0002000000 00 0 00000000 00000000 c0
uart_rx_low 0 0 ffffffff 00 0000000000 1ffbffffff 00 00 0
00fdffffff 00 0 00000000 fbffffff 00
spi_passthru 0 0 12345678 2a 0000000000 0000000000 3f 2a 3
0010345678 15 0 00000000 00000000 3b
# spi pads with the tap
tap_sel_one 1 2 00000000 29 0000000000 0000000000 00 00 2
0000000000 20 b 00000000 00000000 20
tap_sel_two 2 1 00000000 57 0000000000 0000000000 3f 3f 1
1802000000 30 4 00000000 00000000 1f
tap_sel_three 3 3 deadbeef 7f 1234567890 0000000000 00 3f 3
18deadbeef 30 d 30567890 00000000 b5
# straps back to zero, pads return to the core
back_to_spi 0 0 00000000 3e 0000000000 0000000000 02 02 3
1800000000 1d 0 00000000 00000000 30

/* chip_shell.f */
verilog/chip_shell_pkg.sv
verilog/por_gen.sv
verilog/pad_map.sv
verilog/strap_regs.sv
verilog/tap_pad_mux.sv
verilog/chip_shell_top.sv
tests/chip_shell_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the chip shell testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module chip_shell_tb -Mdir obj_dir -f chip_shell.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vchip_shell_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit "$sim_status"
fi

echo "simulation finished with status 0"
exit 0

/* tests/chip_shell_tb.sv */
// chip shell testbench
// replays the records of the test data file, then random gpio traffic

`default_nettype none

module chip_shell_tb;

  logic                          clk_aon;
  logic                          arst_n_i;
  logic [31:0]                   gpio_p2d;
  // {uart_rx, sck, csb, sdi, usb_sense, usb_dp, usb_dn}
  logic [6:0]                    pins;
  chip_shell_pkg::mio_io_t       core_mio;
  chip_shell_pkg::dio_io_t       core_dio;
  chip_shell_pkg::jtag_rsp_t     core_jtag;
  logic [31:0]                   gpio_d2p;
  logic [31:0]                   gpio_en_d2p;
  // {uart_tx, uart_tx_en, spi_sdo, spi_sdo_en, usb_dp, usb_dp_en, usb_dn, usb_dn_en}
  logic [7:0]                    misc;
  logic [36:0]                   core_mio_in;
  logic [5:0]                    core_dio_in;
  chip_shell_pkg::jtag_req_t     jtag_req;
  logic                          core_rst_n;
  chip_shell_pkg::strap_t        strap;

  // current record
  int          fd;
  string       name;
  logic [1:0]  tap;
  logic [1:0]  dft;
  logic [31:0] gpio_w;
  logic [6:0]  pins_w;
  logic [36:0] mout;
  logic [36:0] moe;
  logic [5:0]  dout;
  logic [5:0]  doe;
  logic [1:0]  jrsp;
  logic [36:0] exp_mio_in;
  logic [5:0]  exp_dio_in;
  logic [3:0]  exp_jtag;
  logic [31:0] exp_gout;
  logic [31:0] exp_gen;
  logic [7:0]  exp_misc;
  logic [4:0]  strap_exp;

  chip_shell_top u_dut (
    .clk_aon       (clk_aon),
    .arst_n_i      (arst_n_i),
    .gpio_p2d_i    (gpio_p2d),
    .uart_rx_i     (pins[6]),
    .spi_sck_i     (pins[5]),
    .spi_csb_i     (pins[4]),
    .spi_sdi_i     (pins[3]),
    .usb_sense_i   (pins[2]),
    .usb_dp_i      (pins[1]),
    .usb_dn_i      (pins[0]),
    .gpio_d2p_o    (gpio_d2p),
    .gpio_en_d2p_o (gpio_en_d2p),
    .uart_tx_o     (misc[7]),
    .uart_tx_en_o  (misc[6]),
    .spi_sdo_o     (misc[5]),
    .spi_sdo_en_o  (misc[4]),
    .usb_dp_o      (misc[3]),
    .usb_dp_en_o   (misc[2]),
    .usb_dn_o      (misc[1]),
    .usb_dn_en_o   (misc[0]),
    .core_mio_i    (core_mio),
    .core_dio_i    (core_dio),
    .core_jtag_i   (core_jtag),
    .core_mio_in_o (core_mio_in),
    .core_dio_in_o (core_dio_in),
    .core_jtag_o   (jtag_req),
    .core_rst_n_o  (core_rst_n),
    .strap_o       (strap)
  );

  initial begin
    clk_aon = 1'b0;
    forever #2 clk_aon = ~clk_aon;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string label, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                          label, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // all inputs change together just after a rising edge
  task automatic drive_inputs(input logic [31:0] g, input logic [6:0] p,
                              input logic [73:0] mio, input logic [11:0] dio,
                              input logic [1:0] rsp);
    @(posedge clk_aon);
    gpio_p2d  <= g;
    pins      <= p;
    core_mio  <= mio;
    core_dio  <= dio;
    core_jtag <= rsp;
  endtask

  // reset with the straps on their pins, then watch power-ok
  task automatic power_up(input logic [1:0] tap_s, input logic [1:0] dft_s);
    logic [31:0] straps;
    logic        prev;
    int          rises;
    int          n;
    straps = '0;
    straps[chip_shell_pkg::MioTapStrap1] = tap_s[1];
    straps[chip_shell_pkg::MioTapStrap0] = tap_s[0];
    straps[chip_shell_pkg::MioDftStrap1] = dft_s[1];
    straps[chip_shell_pkg::MioDftStrap0] = dft_s[0];
    drive_inputs(straps, '0, '0, '0, '0);
    arst_n_i <= 1'b0;
    repeat (3) @(posedge clk_aon);
    arst_n_i <= 1'b1;
    prev  = 1'b0;
    rises = 0;
    // glitch pulse first, then the real rise
    repeat (40) begin
      @(negedge clk_aon);
      if (core_rst_n && !prev) rises++;
      prev = core_rst_n;
    end
    check_value({name, " power-ok rises"}, 64'(2), 64'(rises));
    repeat (20) begin
      @(negedge clk_aon);
      check_value({name, " power-ok held"}, 64'(1), 64'(core_rst_n));
    end
    n = 0;
    while (!strap.valid && n < 50) begin
      @(negedge clk_aon);
      n++;
    end
    if (!strap.valid) abort_run({name, ": strap valid never set after power-up"});
    strap_exp = {1'b1, tap_s, dft_s};
    check_value({name, " strap"}, 64'(strap_exp), 64'(strap));
  endtask

  // skips blank lines and comments
  task automatic next_line(output bit found, output string line);
    int code;
    found = 1'b0;
    code  = 1;
    while (!found && code != 0) begin
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 1 && line.getc(0) != "#") found = 1'b1;
    end
  endtask

  task automatic parse_stimulus(input string line);
    string rest;
    int    sp;
    int    cnt;
    sp = 0;
    while (sp < line.len() && line.getc(sp) != " ") sp++;
    name = line.substr(0, sp - 1);
    rest = line.substr(sp, line.len() - 1);
    cnt  = $sscanf(rest, "%h %h %h %h %h %h %h %h %h",
                   tap, dft, gpio_w, pins_w, mout, moe, dout, doe, jrsp);
    if (cnt != 9) abort_run({"malformed stimulus line for ", name});
  endtask

  task automatic parse_expected(input string line);
    int cnt;
    cnt = $sscanf(line, "%h %h %h %h %h %h",
                  exp_mio_in, exp_dio_in, exp_jtag, exp_gout, exp_gen, exp_misc);
    if (cnt != 6) abort_run({"malformed expected line for ", name});
  endtask

  // random pins, core words and tdo after the last record
  // straps hold their last capture
  task automatic random_traffic(input int count);
    logic [31:0] r;
    logic [31:0] g;
    logic [6:0]  p;
    logic [36:0] mo;
    logic [11:0] d;
    logic [1:0]  j;
    logic        tap_on;
    logic [36:0] exp_in;
    logic [5:0]  exp_din;
    logic [3:0]  exp_j;
    logic [31:0] exp_g;
    logic [31:0] exp_e;
    logic [7:0]  exp_m;
    string       lbl;
    r      = 32'h240d;
    tap_on = |strap_exp[3:2];
    for (int i = 0; i < count; i++) begin
      lbl = $sformatf("random_%0d", i);
      r   = xorshift32(r);
      g   = r;
      r   = xorshift32(r);
      p   = r[6:0];
      mo  = {r[31:27], g ^ r};
      r   = xorshift32(r);
      d   = r[11:0];
      j   = r[13:12];
      drive_inputs(g, p, {mo, ~mo}, d, j);
      @(negedge clk_aon);
      exp_in = {p[2], p[2], 3'b000, g};
      exp_in[chip_shell_pkg::MioUartRx] = p[6];
      exp_g = mo[31:0];
      exp_g[chip_shell_pkg::MioUartTx] = 1'b0;
      exp_e = ~mo[31:0];
      exp_e[chip_shell_pkg::MioUartTx] = 1'b0;
      // core dio out sits in d[11:6], oe in d[5:0]
      exp_din = {p[0], p[1], p[4], p[5], 1'b0, p[3]};
      exp_j   = '0;
      exp_m   = {mo[26], ~mo[26], d[7], d[1], d[10], d[4], d[11], d[5]};
      if (tap_on) begin
        exp_din[3:2] = 2'b00;
        exp_din[0]   = 1'b0;
        exp_j        = {p[5], p[4], ~p[4], p[3]};
        exp_m[5:4]   = j;
      end
      check_value({lbl, " core_mio_in"}, 64'(exp_in), 64'(core_mio_in));
      check_value({lbl, " core_dio_in"}, 64'(exp_din), 64'(core_dio_in));
      check_value({lbl, " core_jtag"}, 64'(exp_j), 64'(jtag_req));
      check_value({lbl, " gpio_d2p"}, 64'(exp_g), 64'(gpio_d2p));
      check_value({lbl, " gpio_en_d2p"}, 64'(exp_e), 64'(gpio_en_d2p));
      check_value({lbl, " misc pins"}, 64'(exp_m), 64'(misc));
      check_value({lbl, " strap"}, 64'(strap_exp), 64'(strap));
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    string line;
    bit    found;
    int    records;
    arst_n_i  <= 1'b0;
    gpio_p2d  <= '0;
    pins      <= '0;
    core_mio  <= '0;
    core_dio  <= '0;
    core_jtag <= '0;
    fd = $fopen("tests/chip_shell_testdata.txt", "r");
    if (fd == 0) abort_run("cannot open tests/chip_shell_testdata.txt");
    records = 0;
    next_line(found, line);
    while (found) begin
      parse_stimulus(line);
      next_line(found, line);
      if (!found) abort_run({"expected values missing for ", name});
      parse_expected(line);
      power_up(tap, dft);
      drive_inputs(gpio_w, pins_w, {mout, moe}, {dout, doe}, jrsp);
      @(negedge clk_aon);
      check_value({name, " core_mio_in"}, 64'(exp_mio_in), 64'(core_mio_in));
      check_value({name, " core_dio_in"}, 64'(exp_dio_in), 64'(core_dio_in));
      check_value({name, " core_jtag"}, 64'(exp_jtag), 64'(jtag_req));
      check_value({name, " gpio_d2p"}, 64'(exp_gout), 64'(gpio_d2p));
      check_value({name, " gpio_en_d2p"}, 64'(exp_gen), 64'(gpio_en_d2p));
      check_value({name, " misc pins"}, 64'(exp_misc), 64'(misc));
      check_value({name, " strap after pin change"}, 64'(strap_exp), 64'(strap));
      records++;
      next_line(found, line);
    end
    $fclose(fd);
    if (records == 0) abort_run("no records found in the test data file");
    random_traffic(16);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/chip_shell_top.sv */
// chip shell top level
// power-on, pad mapping, strap capture and tap pad routing around the core ports

`default_nettype none

module chip_shell_top (
  input  wire                                 clk_aon,
  input  wire                                 arst_n_i,
  // chip pins
  input  wire  [31:0]                         gpio_p2d_i,
  input  wire                                 uart_rx_i,
  input  wire                                 spi_sck_i,
  input  wire                                 spi_csb_i,
  input  wire                                 spi_sdi_i,
  input  wire                                 usb_sense_i,
  input  wire                                 usb_dp_i,
  input  wire                                 usb_dn_i,
  output logic [31:0]                         gpio_d2p_o,
  output logic [31:0]                         gpio_en_d2p_o,
  output logic                                uart_tx_o,
  output logic                                uart_tx_en_o,
  output logic                                spi_sdo_o,
  output logic                                spi_sdo_en_o,
  output logic                                usb_dp_o,
  output logic                                usb_dp_en_o,
  output logic                                usb_dn_o,
  output logic                                usb_dn_en_o,
  // core side
  input  chip_shell_pkg::mio_io_t             core_mio_i,
  input  chip_shell_pkg::dio_io_t             core_dio_i,
  input  chip_shell_pkg::jtag_rsp_t           core_jtag_i,
  output logic [chip_shell_pkg::NMioPads-1:0] core_mio_in_o,
  output logic [chip_shell_pkg::NDioPads-1:0] core_dio_in_o,
  output chip_shell_pkg::jtag_req_t           core_jtag_o,
  output logic                                core_rst_n_o,
  output chip_shell_pkg::strap_t              strap_o
);

  logic [chip_shell_pkg::NDioPads-1:0] raw_dio_in;
  chip_shell_pkg::dio_io_t             pad_dio;

  ////////////////////////////////////////
  // power-on and straps
  ////////////////////////////////////////

  // power-ok is the core reset
  por_gen u_por_gen (
    .clk_aon  (clk_aon),
    .arst_n_i (arst_n_i),
    .pok_o    (core_rst_n_o)
  );

  // straps read straight off the mapped mio inputs
  strap_regs u_strap_regs (
    .clk_aon  (clk_aon),
    .arst_n_i (arst_n_i),
    .pok_i    (core_rst_n_o),
    .mio_in_i (core_mio_in_o),
    .strap_o  (strap_o)
  );

  ////////////////////////////////////////
  // pads
  ////////////////////////////////////////

  pad_map u_pad_map (
    .gpio_p2d_i    (gpio_p2d_i),
    .uart_rx_i     (uart_rx_i),
    .spi_sck_i     (spi_sck_i),
    .spi_csb_i     (spi_csb_i),
    .spi_sdi_i     (spi_sdi_i),
    .usb_sense_i   (usb_sense_i),
    .usb_dp_i      (usb_dp_i),
    .usb_dn_i      (usb_dn_i),
    .mio_i         (core_mio_i),
    .dio_i         (pad_dio),
    .mio_in_o      (core_mio_in_o),
    .dio_in_o      (raw_dio_in),
    .gpio_d2p_o    (gpio_d2p_o),
    .gpio_en_d2p_o (gpio_en_d2p_o),
    .uart_tx_o     (uart_tx_o),
    .uart_tx_en_o  (uart_tx_en_o),
    .spi_sdo_o     (spi_sdo_o),
    .spi_sdo_en_o  (spi_sdo_en_o),
    .usb_dp_o      (usb_dp_o),
    .usb_dp_en_o   (usb_dp_en_o),
    .usb_dn_o      (usb_dn_o),
    .usb_dn_en_o   (usb_dn_en_o)
  );

  tap_pad_mux u_tap_pad_mux (
    .tap_sel_i  (strap_o.tap_sel),
    .dio_in_i   (raw_dio_in),
    .core_dio_i (core_dio_i),
    .jtag_rsp_i (core_jtag_i),
    .dio_in_o   (core_dio_in_o),
    .dio_io_o   (pad_dio),
    .jtag_req_o (core_jtag_o)
  );

endmodule

`default_nettype wire

/* verilog/tap_pad_mux.sv */
// tap pad mux
// shares the spi device pads between the core dio and the jtag port

`default_nettype none

module tap_pad_mux (
  input  wire  [1:0]                          tap_sel_i,
  input  wire  [chip_shell_pkg::NDioPads-1:0] dio_in_i,
  input  chip_shell_pkg::dio_io_t             core_dio_i,
  input  chip_shell_pkg::jtag_rsp_t           jtag_rsp_i,
  output logic [chip_shell_pkg::NDioPads-1:0] dio_in_o,
  output chip_shell_pkg::dio_io_t             dio_io_o,
  output chip_shell_pkg::jtag_req_t           jtag_req_o
);

  logic tap_en;

  assign tap_en = |tap_sel_i;

  ////////////////////////////////////////
  // pad side to core and tap
  ////////////////////////////////////////

  always_comb begin
    dio_in_o   = dio_in_i;
    jtag_req_o = '0;
    if (tap_en) begin
      jtag_req_o.tck    = dio_in_i[chip_shell_pkg::DioSpiSck];
      jtag_req_o.tms    = dio_in_i[chip_shell_pkg::DioSpiCsb];
      jtag_req_o.tdi    = dio_in_i[chip_shell_pkg::DioSpiSd0];
      // no trst pad on this build, csb low holds the tap out of reset
      jtag_req_o.trst_n = ~dio_in_i[chip_shell_pkg::DioSpiCsb];
      // spi device sees idle pads while the tap owns them
      dio_in_o[chip_shell_pkg::DioSpiSck] = 1'b0;
      dio_in_o[chip_shell_pkg::DioSpiCsb] = 1'b0;
      dio_in_o[chip_shell_pkg::DioSpiSd0] = 1'b0;
    end
  end

  ////////////////////////////////////////
  // core and tap to pad side
  ////////////////////////////////////////

  // usb bits are never touched
  always_comb begin
    dio_io_o = core_dio_i;
    if (tap_en) begin
      dio_io_o.out[chip_shell_pkg::DioSpiSd1] = jtag_rsp_i.tdo;
      dio_io_o.oe[chip_shell_pkg::DioSpiSd1]  = jtag_rsp_i.tdo_oe;
    end
  end

endmodule

`default_nettype wire

/* verilog/strap_regs.sv */
// strap registers
// samples tap and dft straps on each rising edge of power-ok

`default_nettype none

module strap_regs (
  input  wire                                 clk_aon,
  input  wire                                 arst_n_i,
  input  wire                                 pok_i,
  input  wire  [chip_shell_pkg::NMioPads-1:0] mio_in_i,
  output chip_shell_pkg::strap_t              strap_o
);

  logic pok_q;
  logic pok_rise;

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pok_q <= 1'b0;
    end else begin
      pok_q <= pok_i;
    end
  end

  assign pok_rise = pok_i & ~pok_q;

  // tap_sel steers the pad mux, so it must come out of reset idle
  // a second power-ok pulse recaptures, the last capture wins
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_o <= '0;
    end else if (pok_rise) begin
      strap_o.valid   <= 1'b1;
      strap_o.tap_sel <= {mio_in_i[chip_shell_pkg::MioTapStrap1],
                          mio_in_i[chip_shell_pkg::MioTapStrap0]};
      strap_o.dft_sel <= {mio_in_i[chip_shell_pkg::MioDftStrap1],
                          mio_in_i[chip_shell_pkg::MioDftStrap0]};
    end
  end

endmodule

`default_nettype wire

/* verilog/pad_map.sv */
// pad map
// chip pins onto the raw mio/dio input vectors and pad outputs back onto the pins

`default_nettype none

module pad_map (
  // chip input pins
  input  wire  [31:0]                            gpio_p2d_i,
  input  wire                                    uart_rx_i,
  input  wire                                    spi_sck_i,
  input  wire                                    spi_csb_i,
  input  wire                                    spi_sdi_i,
  input  wire                                    usb_sense_i,
  input  wire                                    usb_dp_i,
  input  wire                                    usb_dn_i,
  // pad outputs from the core side
  input  chip_shell_pkg::mio_io_t                mio_i,
  input  chip_shell_pkg::dio_io_t                dio_i,
  // raw pad inputs
  output logic [chip_shell_pkg::NMioPads-1:0]    mio_in_o,
  output logic [chip_shell_pkg::NDioPads-1:0]    dio_in_o,
  // chip output pins
  output logic [31:0]                            gpio_d2p_o,
  output logic [31:0]                            gpio_en_d2p_o,
  output logic                                   uart_tx_o,
  output logic                                   uart_tx_en_o,
  output logic                                   spi_sdo_o,
  output logic                                   spi_sdo_en_o,
  output logic                                   usb_dp_o,
  output logic                                   usb_dp_en_o,
  output logic                                   usb_dn_o,
  output logic                                   usb_dn_en_o
);

  ////////////////////////////////////////
  // pins to pads
  ////////////////////////////////////////

  always_comb begin
    mio_in_o = '0;
    mio_in_o[31:0] = gpio_p2d_i;
    mio_in_o[chip_shell_pkg::MioUartRx] = uart_rx_i;
    // both sense pads see the same pin
    mio_in_o[chip_shell_pkg::MioUsbSense0] = usb_sense_i;
    mio_in_o[chip_shell_pkg::MioUsbSense1] = usb_sense_i;
  end

  // sd1 is output only on this chip
  always_comb begin
    dio_in_o = '0;
    dio_in_o[chip_shell_pkg::DioSpiSd0] = spi_sdi_i;
    dio_in_o[chip_shell_pkg::DioSpiSck] = spi_sck_i;
    dio_in_o[chip_shell_pkg::DioSpiCsb] = spi_csb_i;
    dio_in_o[chip_shell_pkg::DioUsbDp]  = usb_dp_i;
    dio_in_o[chip_shell_pkg::DioUsbDn]  = usb_dn_i;
  end

  ////////////////////////////////////////
  // pads to pins
  ////////////////////////////////////////

  // gpio 26 is taken by uart tx
  always_comb begin
    gpio_d2p_o    = mio_i.out[31:0];
    gpio_en_d2p_o = mio_i.oe[31:0];
    gpio_d2p_o[chip_shell_pkg::MioUartTx]    = 1'b0;
    gpio_en_d2p_o[chip_shell_pkg::MioUartTx] = 1'b0;
  end

  assign uart_tx_o    = mio_i.out[chip_shell_pkg::MioUartTx];
  assign uart_tx_en_o = mio_i.oe[chip_shell_pkg::MioUartTx];

  assign spi_sdo_o    = dio_i.out[chip_shell_pkg::DioSpiSd1];
  assign spi_sdo_en_o = dio_i.oe[chip_shell_pkg::DioSpiSd1];

  assign usb_dp_o     = dio_i.out[chip_shell_pkg::DioUsbDp];
  assign usb_dp_en_o  = dio_i.oe[chip_shell_pkg::DioUsbDp];
  assign usb_dn_o     = dio_i.out[chip_shell_pkg::DioUsbDn];
  assign usb_dn_en_o  = dio_i.oe[chip_shell_pkg::DioUsbDn];

endmodule

`default_nettype wire

/* verilog/por_gen.sv */
// power-on generator
// emulates a supply that glitches at power-up and filters it into power-ok

`default_nettype none

module por_gen (
  input  wire  clk_aon,
  input  wire  arst_n_i,
  output logic pok_o
);

  logic [chip_shell_pkg::PorCntWidth-1:0]  cnt;
  logic                                    vcc_supp;
  logic [chip_shell_pkg::PokFiltWidth-1:0] hi_cnt;

  // free-running until saturation at all ones
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt <= '0;
    end else if (cnt != '1) begin
      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // emulated supply: low, high, low, high
  ////////////////////////////////////////

  always_comb begin
    if (cnt < chip_shell_pkg::PorGlitchLo) begin
      vcc_supp = 1'b0;
    end else if (cnt < chip_shell_pkg::PorGlitchHi) begin
      vcc_supp = 1'b1;
    end else if (cnt < chip_shell_pkg::PorSettle) begin
      vcc_supp = 1'b0;
    end else begin
      vcc_supp = 1'b1;
    end
  end

  // count consecutive high samples, any low sample drops pok next cycle
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hi_cnt <= '0;
      pok_o  <= 1'b0;
    end else if (!vcc_supp) begin
      hi_cnt <= '0;
      pok_o  <= 1'b0;
    end else begin
      if (hi_cnt < chip_shell_pkg::PokFilterCycles) begin
        hi_cnt <= hi_cnt + 1'b1;
      end
      // this sample is the last one the filter needs
      pok_o <= (hi_cnt >= chip_shell_pkg::PokFilterCycles - 1);
    end
  end

endmodule

`default_nettype wire

/* verilog/chip_shell_pkg.sv */
// chip shell package
// pad counts, pad and strap positions, power-on constants and the shared structs

`default_nettype none

package chip_shell_pkg;

  ////////////////////////////////////////
  // pad counts and positions
  ////////////////////////////////////////

  localparam int unsigned NMioPads = 37;
  localparam int unsigned NDioPads = 6;

  // dedicated pads
  localparam int unsigned DioSpiSd0 = 0;
  localparam int unsigned DioSpiSd1 = 1;
  localparam int unsigned DioSpiSck = 2;
  localparam int unsigned DioSpiCsb = 3;
  localparam int unsigned DioUsbDp  = 4;
  localparam int unsigned DioUsbDn  = 5;

  // multiplexed pads with a fixed role
  localparam int unsigned MioUartRx    = 25;
  localparam int unsigned MioUartTx    = 26;
  localparam int unsigned MioUsbSense0 = 35;
  localparam int unsigned MioUsbSense1 = 36;
  // nominal trst position, trst is taken from the csb pad instead
  localparam int unsigned MioTrst      = 18;

  // strap pins, sampled when power-ok rises
  localparam int unsigned MioTapStrap0 = 26;
  localparam int unsigned MioTapStrap1 = 16;
  localparam int unsigned MioDftStrap0 = 21;
  localparam int unsigned MioDftStrap1 = 22;

  ////////////////////////////////////////
  // power-on emulation
  ////////////////////////////////////////

  localparam int unsigned PorCntWidth     = 4;
  localparam int unsigned PorGlitchLo     = 4;
  localparam int unsigned PorGlitchHi     = 8;
  localparam int unsigned PorSettle       = 12;
  localparam int unsigned PokFilterCycles = 3;
  localparam int unsigned PokFiltWidth    = $clog2(PokFilterCycles + 1);

  ////////////////////////////////////////
  // shared structs
  ////////////////////////////////////////

  // out and oe of one pad class
  typedef struct packed {
    logic [NMioPads-1:0] out;
    logic [NMioPads-1:0] oe;
  } mio_io_t;

  typedef struct packed {
    logic [NDioPads-1:0] out;
    logic [NDioPads-1:0] oe;
  } dio_io_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic tdi;
  } jtag_req_t;

  typedef struct packed {
    logic tdo;
    logic tdo_oe;
  } jtag_rsp_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] tap_sel;
    logic [1:0] dft_sel;
  } strap_t;

endpackage

`default_nettype wire
